/* verilog.f */
mips_pkg.sv
ex_alu.sv
ex_mem.sv
mem_stage.sv
pipe_ctrl_regs.sv
exmem_top.sv
tb_exmem_chk.sv
tb_exmem.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_exmem
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

/* tb_exmem.sv */
`timescale 1ns/1ps

module tb_exmem;
    import mips_pkg::*;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid, issue_ready, wb_valid, exc_valid;
    alu_op_t issue_op;
    reg_addr_t issue_rd, wb_rd;
    word_t issue_a, issue_b, wb_data, pwdata, prdata;
    logic [15:0] issue_imm;
    addr_t issue_pc, wb_pc, exc_pc;
    dword_t hilo;
    logic [3:0] paddr;
    logic psel, penable, pwrite, pready, pslverr;

    integer seed = 32'hae35;
    int cycle = 0;
    int exp_retired = 0;
    word_t model_mem [DMEM_WORDS];
    dword_t model_hilo = '0;
    reg_addr_t exp_rd_q[$];
    word_t exp_data_q[$];
    addr_t exp_pc_q[$];
    int exp_cyc_q[$];

    always #4 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    exmem_top dut_i (.*);

    task automatic fail_stop();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timeout_stop(input string what);
        $display("timed out while %s", what);
        fail_stop();
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_dword(input dword_t got, input dword_t exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // expected result from the instruction rules, updates the model ram and hi/lo.
    function automatic void predict(input alu_op_t op, input word_t a, input word_t b,
                                    input logic [15:0] imm, input reg_addr_t rd,
                                    output logic wr, output word_t data, output logic ovf);
        word_t addr;
        longint wide;
        addr = a + {{16{imm[15]}}, imm};
        wr   = 1'b1;
        data = '0;
        ovf  = 1'b0;
        case (op)
            ADD, SUB: begin
                if (op == ADD) wide = longint'($signed(a)) + longint'($signed(b));
                else wide = longint'($signed(a)) - longint'($signed(b));
                data = wide[31:0];
                ovf  = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
                wr   = !ovf;
            end
            ADDU: data = a + b;
            AND:  data = a & b;
            OR:   data = a | b;
            XOR:  data = a ^ b;
            SLT:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL:  data = a << b[4:0];
            LUI:  data = {imm, 16'h0000};
            LW:   data = model_mem[addr[9:2]];
            MULT: begin
                model_hilo = longint'($signed(a)) * longint'($signed(b));
                wr = 1'b0;
            end
            SW: begin
                model_mem[addr[9:2]] = b;
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (rd == 5'd0) wr = 1'b0;
    endfunction

    // called 1 ns after an edge, returns 1 ns after the accepting edge.
    task automatic issue(input alu_op_t op, input reg_addr_t rd, input word_t a,
                         input word_t b, input logic [15:0] imm, input addr_t pc,
                         input logic check_lat, input logic keep);
        int t;
        logic wr;
        logic ovf;
        word_t data;
        t = 0;
        while (!issue_ready) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 50) timeout_stop("waiting for issue_ready");
        end
        {issue_valid, issue_op, issue_rd} = {1'b1, op, rd};
        {issue_a, issue_b, issue_imm, issue_pc} = {a, b, imm, pc};
        if (keep) begin
            predict(op, a, b, imm, rd, wr, data, ovf);
            if (wr) begin
                exp_rd_q.push_back(rd);
                exp_data_q.push_back(data);
                exp_pc_q.push_back(pc);
                exp_cyc_q.push_back(check_lat ? cycle + 2 : -1);
            end
            if (wr || op == SW) exp_retired++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int t;
        issue_valid = 1'b0;
        t = 0;
        while (exp_rd_q.size() != 0 || t < 3) begin
            @(posedge clk);
            #1;
            t++;
            if (t > 100) timeout_stop("draining the pipeline");
        end
    endtask

    task automatic apb_access(input logic [3:0] addr, input logic wr, input word_t wdata,
                              output word_t rdata, output logic err);
        int t;
        {psel, penable, pwrite, paddr, pwdata} = {1'b1, 1'b0, wr, addr, wdata};
        @(posedge clk);
        #1;
        penable = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > 20) timeout_stop("waiting for pready");
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        {psel, penable, pwrite} = 3'b000;
    endtask

    task automatic apb_write(input logic [3:0] addr, input word_t data, output logic err);
        word_t dummy;
        apb_access(addr, 1'b1, data, dummy, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output word_t data, output logic err);
        apb_access(addr, 1'b0, '0, data, err);
    endtask

    // compare process for register writebacks.
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("writeback to r%0d with no expected result", wb_rd);
                fail_stop();
            end
            check_rd(wb_rd, exp_rd_q.pop_front(), "wb_rd");
            check_word(wb_data, exp_data_q.pop_front(), "wb_data");
            check_word(wb_pc, exp_pc_q.pop_front(), "wb_pc");
            if (exp_cyc_q[0] >= 0 && exp_cyc_q[0] != cycle) begin
                $display("Error at %0t: writeback latency wrong, cycle %0d expected %0d",
                         $time, cycle, exp_cyc_q[0]);
                fail_stop();
            end
            void'(exp_cyc_q.pop_front());
        end
    end

    initial begin
        alu_op_t ops[9];
        word_t rdata, r0;
        logic err;
        int t;
        ops = '{ADD, ADDU, SUB, AND, OR, XOR, SLT, SLL, LUI};
        {rst, issue_valid, issue_op, issue_rd} = {1'b1, 1'b0, NOP, 5'd0};
        {issue_a, issue_b, issue_imm, issue_pc} = '0;
        {paddr, psel, penable, pwrite, pwdata} = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        check_bit(issue_ready, 1'b0, "issue_ready after reset");
        check_bit(wb_valid, 1'b0, "wb_valid after reset");
        check_bit(exc_valid, 1'b0, "exc_valid after reset");
        check_dword(hilo, '0, "hilo after reset");
        apb_read(REG_CTRL, rdata, err);
        check_word(rdata, 32'd0, "CTRL after reset");
        apb_write(REG_CTRL, 32'd1, err);
        check_bit(err, 1'b0, "pslverr on CTRL write");
        for (int i = 0; i < 40; i++) begin
            issue(ops[$unsigned($random(seed)) % 9], 5'($random(seed)), $random(seed),
                  $random(seed), 16'($random(seed)), addr_t'(i * 4), 1'b1, 1'b1);
        end
        drain();

        // stores then loads, same and different words
        issue(SW, 5'd0, 32'h40, 32'hcafe0001, 16'h0000, 32'h300, 1'b1, 1'b1);
        issue(SW, 5'd0, 32'h40, 32'h1234abcd, 16'h0004, 32'h304, 1'b1, 1'b1);
        issue(SW, 5'd0, 32'h400, 32'h0badf00d, 16'hfffc, 32'h308, 1'b1, 1'b1);
        issue(LW, 5'd3, 32'h44, 32'h0, 16'h0000, 32'h30c, 1'b1, 1'b1);
        issue(LW, 5'd4, 32'h3fc, 32'h0, 16'h0000, 32'h310, 1'b1, 1'b1);
        issue(SW, 5'd0, 32'h40, 32'h55aa55aa, 16'h0000, 32'h314, 1'b1, 1'b1);
        issue(LW, 5'd5, 32'h40, 32'h0, 16'h0000, 32'h318, 1'b1, 1'b1);
        drain();
        apb_read(REG_RETIRED, rdata, err);
        check_word(rdata, word_t'(exp_retired), "RETIRED");

        issue(MULT, 5'd7, 32'hfffff001, 32'h7ffe1234, 16'h0, 32'h400, 1'b1, 1'b1);
        drain();
        check_dword(hilo, model_hilo, "hilo after MULT");

        issue(ADD, 5'd9, 32'h7fffffff, 32'h1, 16'h0, 32'h500, 1'b1, 1'b1);
        issue_valid = 1'b0;
        t = 0;
        while (!exc_valid) begin
            @(negedge clk);
            t++;
            if (t > 20) timeout_stop("waiting for exc_valid");
        end
        check_word(exc_pc, 32'h500, "exc_pc");
        @(posedge clk);
        #1;
        drain();
        apb_read(REG_EXCPC, rdata, err);
        check_word(rdata, 32'h500, "EXCPC");

        // freeze with one op held in EX/MEM
        apb_read(REG_RETIRED, r0, err);
        fork
            apb_write(REG_CTRL, 32'd0, err);
            begin
                @(posedge clk);
                #1;
                issue(ADDU, 5'd11, 32'd100, 32'd23, 16'h0, 32'h600, 1'b0, 1'b1);
            end
        join
        issue_valid = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        check_bit(issue_ready, 1'b0, "issue_ready while frozen");
        apb_read(REG_RETIRED, rdata, err);
        check_word(rdata, r0, "RETIRED while frozen");
        apb_write(REG_CTRL, 32'd1, err);
        drain();
        apb_read(REG_RETIRED, rdata, err);
        check_word(rdata, r0 + 32'd1, "RETIRED after unfreeze");

        // freeze again, flush the held op
        fork
            apb_write(REG_CTRL, 32'd0, err);
            begin
                @(posedge clk);
                #1;
                issue(ADDU, 5'd12, 32'd1, 32'd2, 16'h0, 32'h700, 1'b0, 1'b0);
            end
        join
        issue_valid = 1'b0;
        apb_write(REG_FLUSH, 32'd1, err);
        apb_write(REG_CTRL, 32'd1, err);
        drain();
        apb_read(REG_RETIRED, rdata, err);
        check_word(rdata, r0 + 32'd1, "RETIRED after flush");

        apb_read(4'h2, rdata, err);
        check_bit(err, 1'b1, "pslverr on unmapped read");
        apb_write(REG_RETIRED, 32'd5, err);
        check_bit(err, 1'b1, "pslverr on RETIRED write");
        apb_read(REG_CTRL, rdata, err);
        check_bit(err, 1'b0, "pslverr on CTRL read");

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* tb_exmem_chk.sv */
`timescale 1ns/1ps

module tb_exmem_chk (
    input logic                clk,
    input logic                rst,
    input logic                psel,
    input logic                penable,
    input logic                pready,
    input logic                issue_ready,
    input logic                wb_valid,
    input mips_pkg::reg_addr_t wb_rd,
    input logic                exc_valid
);
    a_pready: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> pready)
        else $error("pready low in an access phase");

    a_ready_reset: assert property (@(posedge clk) rst |=> !issue_ready)
        else $error("issue_ready high right after reset");

    // r0 is never a writeback target.
    a_no_r0: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> (wb_rd != 5'd0))
        else $error("writeback to register 0");

    a_excl: assert property (@(posedge clk) disable iff (rst) !(wb_valid && exc_valid))
        else $error("exception and writeback in the same cycle");

endmodule

bind exmem_top tb_exmem_chk chk_i (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pready(pready),
    .issue_ready(issue_ready), .wb_valid(wb_valid), .wb_rd(wb_rd),
    .exc_valid(exc_valid)
);

/* exmem_top.sv */
`timescale 1ns/1ps

module exmem_top (
    input  logic                clk,
    input  logic                rst,

    input  logic                issue_valid,
    input  mips_pkg::alu_op_t   issue_op,
    input  mips_pkg::reg_addr_t issue_rd,
    input  mips_pkg::word_t     issue_a,
    input  mips_pkg::word_t     issue_b,
    input  logic [15:0]         issue_imm,
    input  mips_pkg::addr_t     issue_pc,
    output logic                issue_ready,

    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_rd,
    output mips_pkg::word_t     wb_data,
    output mips_pkg::addr_t     wb_pc,
    output mips_pkg::dword_t    hilo,
    output logic                exc_valid,
    output mips_pkg::addr_t     exc_pc,

    input  logic [3:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mips_pkg::word_t     pwdata,
    output mips_pkg::word_t     prdata,
    output logic                pready,
    output logic                pslverr
);
    import mips_pkg::*;

    alu_op_t   ex_op;
    alu_op_t   mem_op;
    reg_addr_t ex_wd;
    reg_addr_t mem_wd;
    logic      ex_wreg;
    logic      mem_wreg;
    logic      ex_whilo;
    logic      mem_whilo;
    logic      ex_except_ovf;
    logic      mem_except_ovf;
    word_t     ex_wdata;
    word_t     mem_wdata;
    word_t     ex_hi;
    word_t     mem_hi;
    word_t     ex_lo;
    word_t     mem_lo;
    word_t     ex_mem_addr;
    word_t     mem_mem_addr;
    word_t     ex_reg2;
    word_t     mem_reg2;
    addr_t     mem_pc;
    logic      run;
    logic      flush_pulse;
    logic      retire_pulse;

    assign issue_ready = run;

    ex_alu ex_alu_i (
        .issue_valid(issue_valid), .op(issue_op), .rd(issue_rd), .a(issue_a),
        .b(issue_b), .imm(issue_imm), .pc(issue_pc), .out_op(ex_op), .wd(ex_wd),
        .wreg(ex_wreg), .wdata(ex_wdata), .whilo(ex_whilo), .hi(ex_hi), .lo(ex_lo),
        .mem_addr(ex_mem_addr), .reg2(ex_reg2), .except_ovf(ex_except_ovf)
    );

    ex_mem ex_mem_i (
        .clk(clk), .rst(rst), .en(run), .flush(flush_pulse),
        .ex_op(ex_op), .ex_wd(ex_wd), .ex_wreg(ex_wreg), .ex_wdata(ex_wdata),
        .ex_whilo(ex_whilo), .ex_hi(ex_hi), .ex_lo(ex_lo), .ex_mem_addr(ex_mem_addr),
        .ex_reg2(ex_reg2), .ex_pc(issue_pc), .ex_except_ovf(ex_except_ovf),
        .mem_op(mem_op), .mem_wd(mem_wd), .mem_wreg(mem_wreg), .mem_wdata(mem_wdata),
        .mem_whilo(mem_whilo), .mem_hi(mem_hi), .mem_lo(mem_lo),
        .mem_mem_addr(mem_mem_addr), .mem_reg2(mem_reg2), .mem_pc(mem_pc),
        .mem_except_ovf(mem_except_ovf)
    );

    mem_stage mem_stage_i (
        .clk(clk), .rst(rst), .run(run),
        .mem_op(mem_op), .mem_wd(mem_wd), .mem_wreg(mem_wreg), .mem_wdata(mem_wdata),
        .mem_whilo(mem_whilo), .mem_hi(mem_hi), .mem_lo(mem_lo),
        .mem_mem_addr(mem_mem_addr), .mem_reg2(mem_reg2), .mem_pc(mem_pc),
        .mem_except_ovf(mem_except_ovf), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_pc(wb_pc), .hilo(hilo), .exc_valid(exc_valid),
        .retire_pulse(retire_pulse), .exc_pc(exc_pc)
    );

    pipe_ctrl_regs pipe_ctrl_regs_i (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .run(run), .flush_pulse(flush_pulse),
        .retire_pulse(retire_pulse), .exc_valid(exc_valid), .exc_pc(exc_pc)
    );

endmodule

/* pipe_ctrl_regs.sv */
`timescale 1ns/1ps

module pipe_ctrl_regs (
    input  logic            clk,
    input  logic            rst,

    input  logic [3:0]      paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  mips_pkg::word_t pwdata,
    output mips_pkg::word_t prdata,
    output logic            pready,
    output logic            pslverr,

    output logic            run,
    output logic            flush_pulse,

    input  logic            retire_pulse,
    input  logic            exc_valid,
    input  mips_pkg::addr_t exc_pc
);
    import mips_pkg::*;

    logic  access;
    logic  addr_ok;
    logic  ro_reg;
    logic  wr_en;
    word_t retired;
    word_t exc_pc_q;

    assign access = psel && penable;
    assign pready = access;              // no wait states.

    always_comb begin
        case (paddr)
            REG_CTRL, REG_FLUSH, REG_RETIRED, REG_EXCPC: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    assign ro_reg  = (paddr == REG_RETIRED) || (paddr == REG_EXCPC);
    assign pslverr = access && (!addr_ok || (pwrite && ro_reg));
    assign wr_en   = access && pwrite && !pslverr;

    always_comb begin
        case (paddr)
            REG_CTRL:    prdata = {31'b0, run};
            REG_RETIRED: prdata = retired;
            REG_EXCPC:   prdata = exc_pc_q;
            default:     prdata = '0;      // flush reads as zero.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run         <= 1'b0;
            flush_pulse <= 1'b0;
            retired     <= '0;
            exc_pc_q    <= '0;
        end else begin
            flush_pulse <= wr_en && (paddr == REG_FLUSH) && pwdata[0];  // one cycle.
            if (wr_en && (paddr == REG_CTRL)) begin
                run <= pwdata[0];
            end
            if (retire_pulse) begin
                retired <= retired + 32'd1;
            end
            if (exc_valid) begin
                exc_pc_q <= exc_pc;
            end
        end
    end

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,

    input  mips_pkg::alu_op_t   mem_op,
    input  mips_pkg::reg_addr_t mem_wd,
    input  logic                mem_wreg,
    input  mips_pkg::word_t     mem_wdata,
    input  logic                mem_whilo,
    input  mips_pkg::word_t     mem_hi,
    input  mips_pkg::word_t     mem_lo,
    input  mips_pkg::word_t     mem_mem_addr,
    input  mips_pkg::word_t     mem_reg2,
    input  mips_pkg::addr_t     mem_pc,
    input  logic                mem_except_ovf,

    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_rd,
    output mips_pkg::word_t     wb_data,
    output mips_pkg::addr_t     wb_pc,
    output mips_pkg::dword_t    hilo,
    output logic                exc_valid,
    output logic                retire_pulse,
    output mips_pkg::addr_t     exc_pc
);
    import mips_pkg::*;

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] idx;
    logic               is_load;
    logic               is_store;

    assign idx      = mem_mem_addr[DMEM_AW+1:2];   // word index.
    assign is_load  = (mem_op == LW);
    assign is_store = (mem_op == SW);

    // data RAM
    always_ff @(posedge clk) begin
        if (run && is_store) begin
            dmem[idx] <= mem_reg2;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            wb_rd   <= mem_wd;
            wb_data <= is_load ? dmem[idx] : mem_wdata;  // load reads the old word.
            wb_pc   <= mem_pc;
            exc_pc  <= mem_pc;
        end
    end

    // frozen pipe retires nothing.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid     <= 1'b0;
            exc_valid    <= 1'b0;
            retire_pulse <= 1'b0;
            hilo         <= '0;
        end else begin
            wb_valid     <= run && mem_wreg;
            exc_valid    <= run && mem_except_ovf;
            retire_pulse <= run && (mem_wreg || is_store);
            if (run && mem_whilo) begin
                hilo <= {mem_hi, mem_lo};
            end
        end
    end

endmodule

/* ex_mem.sv */
`timescale 1ns/1ps

module ex_mem (
    input  logic                clk,
    input  logic                rst,
    input  logic                en,
    input  logic                flush,

    input  mips_pkg::alu_op_t   ex_op,
    input  mips_pkg::reg_addr_t ex_wd,
    input  logic                ex_wreg,
    input  mips_pkg::word_t     ex_wdata,
    input  logic                ex_whilo,
    input  mips_pkg::word_t     ex_hi,
    input  mips_pkg::word_t     ex_lo,
    input  mips_pkg::word_t     ex_mem_addr,
    input  mips_pkg::word_t     ex_reg2,
    input  mips_pkg::addr_t     ex_pc,
    input  logic                ex_except_ovf,

    output mips_pkg::alu_op_t   mem_op,
    output mips_pkg::reg_addr_t mem_wd,
    output logic                mem_wreg,
    output mips_pkg::word_t     mem_wdata,
    output logic                mem_whilo,
    output mips_pkg::word_t     mem_hi,
    output mips_pkg::word_t     mem_lo,
    output mips_pkg::word_t     mem_mem_addr,
    output mips_pkg::word_t     mem_reg2,
    output mips_pkg::addr_t     mem_pc,
    output logic                mem_except_ovf
);
    import mips_pkg::*;

    always_ff @(posedge clk) begin
        if (rst || flush) begin               // bubble.
            mem_op         <= NOP;
            mem_wd         <= '0;
            mem_wreg       <= 1'b0;
            mem_wdata      <= '0;
            mem_whilo      <= 1'b0;
            mem_hi         <= '0;
            mem_lo         <= '0;
            mem_mem_addr   <= '0;
            mem_reg2       <= '0;
            mem_pc         <= '0;
            mem_except_ovf <= 1'b0;
        end else if (en) begin
            mem_op         <= ex_op;
            mem_wd         <= ex_wd;
            mem_wreg       <= ex_wreg;
            mem_wdata      <= ex_wdata;
            mem_whilo      <= ex_whilo;
            mem_hi         <= ex_hi;
            mem_lo         <= ex_lo;
            mem_mem_addr   <= ex_mem_addr;
            mem_reg2       <= ex_reg2;
            mem_pc         <= ex_pc;
            mem_except_ovf <= ex_except_ovf;
        end
    end

endmodule

/* ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  logic                issue_valid,
    input  mips_pkg::alu_op_t   op,
    input  mips_pkg::reg_addr_t rd,
    input  mips_pkg::word_t     a,
    input  mips_pkg::word_t     b,
    input  logic [15:0]         imm,
    input  mips_pkg::addr_t     pc,

    output mips_pkg::alu_op_t   out_op,
    output mips_pkg::reg_addr_t wd,
    output logic                wreg,
    output mips_pkg::word_t     wdata,
    output logic                whilo,
    output mips_pkg::word_t     hi,
    output mips_pkg::word_t     lo,
    output mips_pkg::word_t     mem_addr,
    output mips_pkg::word_t     reg2,
    output logic                except_ovf
);
    import mips_pkg::*;

    alu_op_t eff_op;
    word_t   imm_ext;
    word_t   sum;
    word_t   diff;
    dword_t  prod;
    logic    add_ovf;
    logic    sub_ovf;
    logic    wr_en;

    assign eff_op  = issue_valid ? op : NOP;  // no valid issue is a bubble.
    assign imm_ext = {{16{imm[15]}}, imm};
    assign sum     = a + b;
    assign diff    = a - b;
    assign prod    = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});

    // same signs in, different sign out.
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        wdata      = '0;
        wr_en      = 1'b0;
        whilo      = 1'b0;
        hi         = '0;
        lo         = '0;
        except_ovf = 1'b0;
        case (eff_op)
            ADD: begin
                wdata      = sum;
                wr_en      = !add_ovf;     // trap cancels the write.
                except_ovf = add_ovf;
            end
            ADDU: begin
                wdata = sum;
                wr_en = 1'b1;
            end
            SUB: begin
                wdata      = diff;
                wr_en      = !sub_ovf;
                except_ovf = sub_ovf;
            end
            AND: begin
                wdata = a & b;
                wr_en = 1'b1;
            end
            OR: begin
                wdata = a | b;
                wr_en = 1'b1;
            end
            XOR: begin
                wdata = a ^ b;
                wr_en = 1'b1;
            end
            SLT: begin
                wdata = {31'b0, ($signed(a) < $signed(b))};
                wr_en = 1'b1;
            end
            SLL: begin
                wdata = a << b[4:0];
                wr_en = 1'b1;
            end
            LUI: begin
                wdata = {imm, 16'b0};
                wr_en = 1'b1;
            end
            MULT: begin
                whilo = 1'b1;
                hi    = prod[63:32];
                lo    = prod[31:0];
            end
            LW: wr_en = 1'b1;                  // data comes from the RAM.
            default: wr_en = 1'b0;             // NOP and SW write no register.
        endcase
    end

    assign out_op   = eff_op;
    assign wd       = rd;
    assign wreg     = wr_en && (rd != 5'd0);   // r0 stays zero.
    assign mem_addr = a + imm_ext;
    assign reg2     = b;

endmodule

/* mips_pkg.sv */
package mips_pkg;

    // data RAM geometry
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = 8;      // index width, byte address bits 9:2.

    // APB register map, byte offsets
    localparam logic [3:0] REG_CTRL    = 4'h0;  // bit 0 is run.
    localparam logic [3:0] REG_FLUSH   = 4'h4;  // write 1 to drop the EX/MEM contents.
    localparam logic [3:0] REG_RETIRED = 4'h8;  // writebacks plus stores.
    localparam logic [3:0] REG_EXCPC   = 4'hc;  // pc of the last overflow.

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [63:0] dword_t;

    // operations issued into the execute stage
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,    // signed, traps on overflow.
        ADDU = 4'd2,
        SUB  = 4'd3,    // signed, traps on overflow.
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        SLT  = 4'd7,    // signed compare.
        SLL  = 4'd8,    // a shifted by b[4:0].
        LUI  = 4'd9,    // imm into the upper half.
        MULT = 4'd10,   // signed 64-bit product into hi/lo.
        LW   = 4'd11,
        SW   = 4'd12
    } alu_op_t;

endpackage
